// ==== compile.f ====
hw/arcade_pkg.sv
hw/key_matrix.sv
hw/joy_conditioner.sv
hw/control_merge.sv
hw/arcade_ctrl_top.sv
tb/tb_arcade_ctrl.sv

// ==== hw/arcade_ctrl_top.sv ====
`timescale 1ns/10ps

module arcade_ctrl_top #(
	parameter int COIN_HOLD = 4
) (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  arcade_pkg::key_code_t key_code,
	input  arcade_pkg::joy_t      joystick_0,
	input  arcade_pkg::joy_t      joystick_1,
	input  logic                  joyswap,
	input  logic                  oneplayer,
	input  logic                  rotate,
	input  arcade_pkg::hwsel_t    hwsel,
	output arcade_pkg::player_t   player1,
	output arcade_pkg::player_t   player2,
	output arcade_pkg::system_t   controls
);

	arcade_pkg::player_t kb_player1;
	arcade_pkg::player_t kb_player2;
	arcade_pkg::system_t kb_system;
	arcade_pkg::player_t joy_player1;
	arcade_pkg::player_t joy_player2;
	arcade_pkg::system_t joy_system;

	key_matrix u_key_matrix (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.kb_player1  (kb_player1),
		.kb_player2  (kb_player2),
		.kb_system   (kb_system)
	);

	joy_conditioner u_joy_conditioner (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.joyswap     (joyswap),
		.oneplayer   (oneplayer),
		.joy_player1 (joy_player1),
		.joy_player2 (joy_player2),
		.joy_system  (joy_system)
	);

	control_merge #(
		.COIN_HOLD (COIN_HOLD)
	) u_control_merge (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.hwsel       (hwsel),
		.rotate      (rotate),
		.kb_player1  (kb_player1),
		.kb_player2  (kb_player2),
		.joy_player1 (joy_player1),
		.joy_player2 (joy_player2),
		.kb_system   (kb_system),
		.joy_system  (joy_system),
		.player1     (player1),
		.player2     (player2),
		.controls    (controls)
	);

endmodule

// ==== hw/arcade_pkg.sv ====
package arcade_pkg;

	typedef logic [5:0] player_t;   // Fire B, fire A, up, down, left, right
	typedef logic [3:0] system_t;   // Coin 2, coin 1, start 2, start 1
	typedef logic [7:0] joy_t;      // Board joystick word
	typedef logic [7:0] key_code_t;
	typedef logic [6:0] hwsel_t;
	typedef logic [1:0] orient_t;   // Bit 0 vertical, bit 1 clockwise

	// Bit positions in player_t
	localparam int P_RIGHT  = 0;
	localparam int P_LEFT   = 1;
	localparam int P_DOWN   = 2;
	localparam int P_UP     = 3;
	localparam int P_FIRE_A = 4;
	localparam int P_FIRE_B = 5;

	// Bit positions in system_t
	localparam int S_START1 = 0;
	localparam int S_START2 = 1;
	localparam int S_COIN1  = 2;
	localparam int S_COIN2  = 3;

	// Buttons in joy_t above the player field
	localparam int J_START = 6;
	localparam int J_COIN  = 7;

	// Player 1 keys
	localparam key_code_t KC_UP    = 8'h75;
	localparam key_code_t KC_DOWN  = 8'h72;
	localparam key_code_t KC_LEFT  = 8'h6B;
	localparam key_code_t KC_RIGHT = 8'h74;
	localparam key_code_t KC_CTRL  = 8'h14;
	localparam key_code_t KC_ALT   = 8'h11;

	// Player 2 keys
	localparam key_code_t KC_R = 8'h2D;
	localparam key_code_t KC_F = 8'h2B;
	localparam key_code_t KC_D = 8'h23;
	localparam key_code_t KC_G = 8'h34;
	localparam key_code_t KC_A = 8'h1C;
	localparam key_code_t KC_S = 8'h1B;

	// System keys
	localparam key_code_t KC_1 = 8'h16;
	localparam key_code_t KC_2 = 8'h1E;
	localparam key_code_t KC_5 = 8'h2E;
	localparam key_code_t KC_6 = 8'h36;

	localparam hwsel_t HW_BATTROAD = 7'h06;
	localparam hwsel_t HW_YOUJYUDN = 7'h0B;

	localparam orient_t ORIENT_NORMAL = 2'b10;
	localparam orient_t ORIENT_CW     = 2'b11;
	localparam orient_t ORIENT_CCW    = 2'b01;

endpackage

// ==== hw/control_merge.sv ====
`timescale 1ns/10ps

module control_merge #(
	parameter int COIN_HOLD = 4
) (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  arcade_pkg::hwsel_t  hwsel,
	input  logic                rotate,
	input  arcade_pkg::player_t kb_player1,
	input  arcade_pkg::player_t kb_player2,
	input  arcade_pkg::player_t joy_player1,
	input  arcade_pkg::player_t joy_player2,
	input  arcade_pkg::system_t kb_system,
	input  arcade_pkg::system_t joy_system,
	output arcade_pkg::player_t player1,
	output arcade_pkg::player_t player2,
	output arcade_pkg::system_t controls
);

	localparam int CNT_W = $clog2(COIN_HOLD + 1);

	arcade_pkg::orient_t orientation;
	arcade_pkg::player_t p1_or;
	arcade_pkg::player_t p2_or;
	arcade_pkg::player_t p1_next;
	arcade_pkg::player_t p2_next;
	arcade_pkg::system_t sys_or;
	logic                do_rotate;
	logic [1:0]          coin_in;
	logic [1:0]          coin_prev;
	logic [1:0]          coin_out;
	logic [1:0]          start_q;

	// Only the direction nibble moves
	function automatic arcade_pkg::player_t rotate_dirs(input arcade_pkg::player_t p,
		input logic cw);
		arcade_pkg::player_t r;
		r = p;
		if (cw) begin
			r[arcade_pkg::P_UP]    = p[arcade_pkg::P_LEFT];
			r[arcade_pkg::P_RIGHT] = p[arcade_pkg::P_UP];
			r[arcade_pkg::P_DOWN]  = p[arcade_pkg::P_RIGHT];
			r[arcade_pkg::P_LEFT]  = p[arcade_pkg::P_DOWN];
		end else begin
			r[arcade_pkg::P_LEFT]  = p[arcade_pkg::P_UP];
			r[arcade_pkg::P_UP]    = p[arcade_pkg::P_RIGHT];
			r[arcade_pkg::P_RIGHT] = p[arcade_pkg::P_DOWN];
			r[arcade_pkg::P_DOWN]  = p[arcade_pkg::P_LEFT];
		end
		return r;
	endfunction

	always_comb begin
		case (hwsel)
			arcade_pkg::HW_BATTROAD: orientation = arcade_pkg::ORIENT_CW;
			arcade_pkg::HW_YOUJYUDN: orientation = arcade_pkg::ORIENT_CCW;
			default:                 orientation = arcade_pkg::ORIENT_NORMAL;
		endcase
	end

	assign p1_or     = kb_player1 | joy_player1;
	assign p2_or     = kb_player2 | joy_player2;
	assign sys_or    = kb_system | joy_system;
	assign do_rotate = rotate & orientation[0]; // Vertical games only

	assign p1_next = do_rotate ? rotate_dirs(p1_or, orientation[1]) : p1_or;
	assign p2_next = do_rotate ? rotate_dirs(p2_or, orientation[1]) : p2_or;

	assign coin_in = {sys_or[arcade_pkg::S_COIN2], sys_or[arcade_pkg::S_COIN1]};

	// One stretcher per coin slot
	for (genvar i = 0; i < 2; i++) begin : g_coin
		logic [CNT_W-1:0] cnt;
		logic [CNT_W-1:0] cnt_next;

		always_comb begin
			cnt_next = cnt;
			if (cnt != '0) begin
				cnt_next = cnt - 1'b1;
			end else if (coin_in[i] && !coin_prev[i]) begin
				cnt_next = CNT_W'(COIN_HOLD); // Presses inside a pulse are dropped
			end
		end

		always_ff @(posedge clk_sys or negedge rst_n) begin
			if (!rst_n) begin
				cnt         <= '0;
				coin_prev[i] <= 1'b0;
				coin_out[i]  <= 1'b0;
			end else begin
				cnt         <= cnt_next;
				coin_prev[i] <= coin_in[i];
				coin_out[i]  <= (cnt_next != '0);
			end
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			player1 <= '0;
			player2 <= '0;
			start_q <= '0;
		end else begin
			player1 <= p1_next;
			player2 <= p2_next;
			start_q <= {sys_or[arcade_pkg::S_START2], sys_or[arcade_pkg::S_START1]};
		end
	end

	assign controls = {coin_out[1], coin_out[0], start_q}; // Coin 2, coin 1, start 2, start 1

endmodule

// ==== hw/joy_conditioner.sv ====
`timescale 1ns/10ps

module joy_conditioner (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  arcade_pkg::joy_t    joystick_0,
	input  arcade_pkg::joy_t    joystick_1,
	input  logic                joyswap,
	input  logic                oneplayer,
	output arcade_pkg::player_t joy_player1,
	output arcade_pkg::player_t joy_player2,
	output arcade_pkg::system_t joy_system
);

	arcade_pkg::joy_t    joy_a;
	arcade_pkg::joy_t    joy_b;
	arcade_pkg::player_t p1_next;
	arcade_pkg::player_t p2_next;
	arcade_pkg::system_t sys_next;

	assign joy_a = joyswap ? joystick_1 : joystick_0; // A feeds player 1
	assign joy_b = joyswap ? joystick_0 : joystick_1;

	always_comb begin
		p1_next  = joy_a[5:0];
		p2_next  = joy_b[5:0];
		sys_next = '0;
		sys_next[arcade_pkg::S_START1] = joy_a[arcade_pkg::J_START];
		sys_next[arcade_pkg::S_COIN1]  = joy_a[arcade_pkg::J_COIN];
		sys_next[arcade_pkg::S_START2] = joy_b[arcade_pkg::J_START];
		sys_next[arcade_pkg::S_COIN2]  = joy_b[arcade_pkg::J_COIN];
		if (oneplayer) begin
			// Either stick plays player 1
			p1_next = joy_a[5:0] | joy_b[5:0];
			p2_next = '0;
			sys_next[arcade_pkg::S_START1] = joy_a[arcade_pkg::J_START] |
				joy_b[arcade_pkg::J_START];
			sys_next[arcade_pkg::S_COIN1] = joy_a[arcade_pkg::J_COIN] |
				joy_b[arcade_pkg::J_COIN];
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			joy_player1 <= '0;
			joy_player2 <= '0;
			joy_system  <= '0;
		end else begin
			joy_player1 <= p1_next;
			joy_player2 <= p2_next;
			joy_system  <= sys_next;
		end
	end

endmodule

// ==== hw/key_matrix.sv ====
`timescale 1ns/10ps

module key_matrix (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  arcade_pkg::key_code_t key_code,
	output arcade_pkg::player_t   kb_player1,
	output arcade_pkg::player_t   kb_player2,
	output arcade_pkg::system_t   kb_system
);

	// Held-key state lives directly in the output vectors
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			kb_player1 <= '0;
			kb_player2 <= '0;
			kb_system  <= '0;
		end else if (key_strobe) begin
			case (key_code)
				arcade_pkg::KC_UP: begin
					kb_player1[arcade_pkg::P_UP] <= key_pressed;
				end
				arcade_pkg::KC_DOWN: begin
					kb_player1[arcade_pkg::P_DOWN] <= key_pressed;
				end
				arcade_pkg::KC_LEFT: begin
					kb_player1[arcade_pkg::P_LEFT] <= key_pressed;
				end
				arcade_pkg::KC_RIGHT: begin
					kb_player1[arcade_pkg::P_RIGHT] <= key_pressed;
				end
				arcade_pkg::KC_CTRL: begin
					kb_player1[arcade_pkg::P_FIRE_A] <= key_pressed;
				end
				arcade_pkg::KC_ALT: begin
					kb_player1[arcade_pkg::P_FIRE_B] <= key_pressed;
				end
				arcade_pkg::KC_R: begin
					kb_player2[arcade_pkg::P_UP] <= key_pressed;
				end
				arcade_pkg::KC_F: begin
					kb_player2[arcade_pkg::P_DOWN] <= key_pressed;
				end
				arcade_pkg::KC_D: begin
					kb_player2[arcade_pkg::P_LEFT] <= key_pressed;
				end
				arcade_pkg::KC_G: begin
					kb_player2[arcade_pkg::P_RIGHT] <= key_pressed;
				end
				arcade_pkg::KC_A: begin
					kb_player2[arcade_pkg::P_FIRE_A] <= key_pressed;
				end
				arcade_pkg::KC_S: begin
					kb_player2[arcade_pkg::P_FIRE_B] <= key_pressed;
				end
				arcade_pkg::KC_1: begin
					kb_system[arcade_pkg::S_START1] <= key_pressed;
				end
				arcade_pkg::KC_2: begin
					kb_system[arcade_pkg::S_START2] <= key_pressed;
				end
				arcade_pkg::KC_5: begin
					kb_system[arcade_pkg::S_COIN1] <= key_pressed;
				end
				arcade_pkg::KC_6: begin
					kb_system[arcade_pkg::S_COIN2] <= key_pressed;
				end
				default: begin
					// Unmapped code leaves held state untouched
				end
			endcase
		end
	end

endmodule

// ==== tb/tb_arcade_ctrl.sv ====
`timescale 1ns/10ps

module tb_arcade_ctrl;

	localparam int COIN_HOLD  = 4;
	localparam int MAX_CYCLES = 2000; // All tests take roughly 350 cycles
	localparam int NUM_KEYS   = 16;

	logic                  clk_sys;
	logic                  rst_n;
	logic                  key_strobe;
	logic                  key_pressed;
	arcade_pkg::key_code_t key_code;
	arcade_pkg::joy_t      joystick_0;
	arcade_pkg::joy_t      joystick_1;
	logic                  joyswap;
	logic                  oneplayer;
	logic                  rotate;
	arcade_pkg::hwsel_t    hwsel;
	arcade_pkg::player_t   player1;
	arcade_pkg::player_t   player2;
	arcade_pkg::system_t   controls;

	int     error_count;
	int     check_count;
	int     cycle_count;
	integer seed;
	int     coin_high;
	int     coin_first;
	int     coin_k;

	arcade_pkg::key_code_t key_list [NUM_KEYS];
	int                    key_group [NUM_KEYS]; // 0 player 1, 1 player 2, 2 system
	int                    key_bit [NUM_KEYS];

	arcade_ctrl_top #(
		.COIN_HOLD (COIN_HOLD)
	) u_arcade_ctrl_top (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.joyswap     (joyswap),
		.oneplayer   (oneplayer),
		.rotate      (rotate),
		.hwsel       (hwsel),
		.player1     (player1),
		.player2     (player2),
		.controls    (controls)
	);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	// Ends 2 ns after the edge, where the next inputs are driven
	task automatic next_cycle;
		@(posedge clk_sys);
		#2;
		key_strobe = 1'b0; // Strobe lasts one cycle
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic send_key(input arcade_pkg::key_code_t code, input logic pressed);
		key_strobe  = 1'b1;
		key_pressed = pressed;
		key_code    = code;
	endtask

	task automatic check_val(input string name, input logic [7:0] got,
		input logic [7:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("ERR %0t %s: got %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic check_outputs(input arcade_pkg::player_t e1, input arcade_pkg::player_t e2,
		input arcade_pkg::system_t es);
		check_val("player1", player1, e1);
		check_val("player2", player2, e2);
		check_val("controls", controls, es);
	endtask

	task automatic set_key(input int idx, input arcade_pkg::key_code_t code,
		input int group, input int bit_idx);
		key_list[idx]  = code;
		key_group[idx] = group;
		key_bit[idx]   = bit_idx;
	endtask

	task automatic load_key_table;
		set_key(0, arcade_pkg::KC_UP, 0, 3);
		set_key(1, arcade_pkg::KC_DOWN, 0, 2);
		set_key(2, arcade_pkg::KC_LEFT, 0, 1);
		set_key(3, arcade_pkg::KC_RIGHT, 0, 0);
		set_key(4, arcade_pkg::KC_CTRL, 0, 4);
		set_key(5, arcade_pkg::KC_ALT, 0, 5);
		set_key(6, arcade_pkg::KC_R, 1, 3);
		set_key(7, arcade_pkg::KC_F, 1, 2);
		set_key(8, arcade_pkg::KC_D, 1, 1);
		set_key(9, arcade_pkg::KC_G, 1, 0);
		set_key(10, arcade_pkg::KC_A, 1, 4);
		set_key(11, arcade_pkg::KC_S, 1, 5);
		set_key(12, arcade_pkg::KC_1, 2, 0);
		set_key(13, arcade_pkg::KC_2, 2, 1);
		set_key(14, arcade_pkg::KC_5, 2, 2);
		set_key(15, arcade_pkg::KC_6, 2, 3);
	endtask

	task automatic keys_and_reset;
		arcade_pkg::player_t e1;
		arcade_pkg::player_t e2;
		arcade_pkg::system_t es;
		check_outputs('0, '0, '0);
		for (int i = 0; i < NUM_KEYS; i++) begin
			e1 = '0;
			e2 = '0;
			es = '0;
			if (key_group[i] == 0) e1[key_bit[i]] = 1'b1;
			else if (key_group[i] == 1) e2[key_bit[i]] = 1'b1;
			else es[key_bit[i]] = 1'b1;
			send_key(key_list[i], 1'b1);
			next_cycle();
			check_outputs('0, '0, '0); // Not visible yet
			next_cycle();
			check_outputs(e1, e2, es);
			wait_cycles(COIN_HOLD); // Coin pulse has ended by now
			check_outputs(e1, e2, es & 4'b0011);
			send_key(key_list[i], 1'b0);
			next_cycle();
			check_outputs(e1, e2, es & 4'b0011);
			next_cycle();
			check_outputs('0, '0, '0);
		end
		// Unmapped code while up is held
		send_key(arcade_pkg::KC_UP, 1'b1);
		wait_cycles(2);
		send_key(8'h55, 1'b1);
		wait_cycles(2);
		check_outputs(6'h08, '0, '0);
		send_key(8'h55, 1'b0);
		wait_cycles(2);
		check_outputs(6'h08, '0, '0);
		send_key(arcade_pkg::KC_UP, 1'b0);
		wait_cycles(2);
		check_outputs('0, '0, '0);
	endtask

	task automatic joystick_paths;
		arcade_pkg::joy_t a;
		arcade_pkg::joy_t b;
		arcade_pkg::joy_t j0;
		arcade_pkg::joy_t j1;
		send_key(arcade_pkg::KC_CTRL, 1'b1); // Held fire A on player 1
		next_cycle();
		send_key(arcade_pkg::KC_G, 1'b1); // Held right on player 2
		wait_cycles(2);
		for (int swap = 0; swap < 2; swap++) begin
			for (int n = 0; n < 8; n++) begin
				j0 = arcade_pkg::joy_t'($random(seed)) & 8'h7F; // Coins tested apart
				j1 = arcade_pkg::joy_t'($random(seed)) & 8'h7F;
				joystick_0 = j0;
				joystick_1 = j1;
				joyswap    = swap[0];
				wait_cycles(2);
				a = swap[0] ? j1 : j0;
				b = swap[0] ? j0 : j1;
				check_outputs(a[5:0] | 6'h10, b[5:0] | 6'h01, {2'b00, b[6], a[6]});
			end
		end
		joystick_0 = '0;
		joystick_1 = '0;
		joyswap    = 1'b0;
		send_key(arcade_pkg::KC_CTRL, 1'b0);
		next_cycle();
		send_key(arcade_pkg::KC_G, 1'b0);
		wait_cycles(2);
		check_outputs('0, '0, '0);
	endtask

	task automatic one_player_fold;
		arcade_pkg::joy_t j0;
		arcade_pkg::joy_t j1;
		oneplayer = 1'b1;
		for (int n = 0; n < 6; n++) begin
			j0 = arcade_pkg::joy_t'($random(seed)) & 8'h7F;
			j1 = arcade_pkg::joy_t'($random(seed)) & 8'h7F;
			if (n == 0) j0 = '0; // Joystick 1 alone first
			joystick_0 = j0;
			joystick_1 = j1;
			wait_cycles(2);
			check_outputs(j0[5:0] | j1[5:0], '0, {2'b00, j1[6], j0[6] | j1[6]});
		end
		oneplayer  = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		wait_cycles(2);
		check_outputs('0, '0, '0);
	endtask

	task automatic check_turn(input arcade_pkg::hwsel_t sel, input logic rot,
		input int dir_in, input int dir_out);
		arcade_pkg::joy_t    j;
		arcade_pkg::player_t e;
		hwsel = sel;
		rotate = rot;
		j = 8'h10;
		j[dir_in] = 1'b1;
		joystick_0 = j;
		joystick_1 = j ^ 8'h30; // Fire B instead of fire A
		e = 6'h10;
		e[dir_out] = 1'b1;
		wait_cycles(2);
		check_outputs(e, e ^ 6'h30, '0);
	endtask

	task automatic direction_rotation;
		int cw_out [4];
		int ccw_out [4];
		cw_out  = '{2, 3, 1, 0}; // Right to down, left to up, down to left, up to right
		ccw_out = '{3, 2, 0, 1};
		for (int d = 0; d < 4; d++) begin
			check_turn(arcade_pkg::HW_BATTROAD, 1'b1, d, cw_out[d]);
			check_turn(arcade_pkg::HW_YOUJYUDN, 1'b1, d, ccw_out[d]);
			check_turn(7'h00, 1'b1, d, d);
			check_turn(7'h00, 1'b0, d, d);
			check_turn(arcade_pkg::HW_BATTROAD, 1'b0, d, d);
		end
		hwsel      = '0;
		rotate     = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		wait_cycles(2);
		check_outputs('0, '0, '0);
	endtask

	task automatic clear_coin_count;
		coin_high  = 0;
		coin_first = -1;
		coin_k     = 0;
	endtask

	task automatic sample_coin(input int bit_idx);
		next_cycle();
		coin_k++;
		if (controls[bit_idx]) begin
			coin_high++;
			if (coin_first < 0) coin_first = coin_k;
		end
	endtask

	task automatic expect_pulse(input int high);
		check_val("coin pulse length", coin_high[7:0], high[7:0]);
		if (high > 0) check_val("coin pulse start", coin_first[7:0], 8'd2);
	endtask

	task automatic coin_pulses;
		// Coin 1 by keyboard held well past the pulse
		clear_coin_count();
		send_key(arcade_pkg::KC_5, 1'b1);
		repeat (12) sample_coin(2);
		expect_pulse(COIN_HOLD);
		clear_coin_count();
		repeat (8) sample_coin(2);
		expect_pulse(0);
		send_key(arcade_pkg::KC_5, 1'b0);
		clear_coin_count();
		repeat (8) sample_coin(2);
		expect_pulse(0);
		// Second press inside the pulse
		clear_coin_count();
		send_key(arcade_pkg::KC_5, 1'b1);
		sample_coin(2);
		send_key(arcade_pkg::KC_5, 1'b0);
		sample_coin(2);
		send_key(arcade_pkg::KC_5, 1'b1);
		repeat (10) sample_coin(2);
		expect_pulse(COIN_HOLD);
		send_key(arcade_pkg::KC_5, 1'b0);
		wait_cycles(4);
		// Coin 2 by joystick 1
		clear_coin_count();
		joystick_1 = 8'h80;
		repeat (12) sample_coin(3);
		expect_pulse(COIN_HOLD);
		clear_coin_count();
		repeat (8) sample_coin(3);
		expect_pulse(0);
		joystick_1 = '0;
		clear_coin_count();
		repeat (6) sample_coin(3);
		expect_pulse(0);
		clear_coin_count();
		joystick_1 = 8'h80;
		sample_coin(3);
		joystick_1 = '0;
		sample_coin(3);
		joystick_1 = 8'h80;
		repeat (10) sample_coin(3);
		expect_pulse(COIN_HOLD);
		joystick_1 = '0;
		wait_cycles(4);
		check_outputs('0, '0, '0);
	endtask

	initial begin
		rst_n       = 1'b0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		joystick_0  = '0;
		joystick_1  = '0;
		joyswap     = 1'b0;
		oneplayer   = 1'b0;
		rotate      = 1'b0;
		hwsel       = '0;
		seed        = 74;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		load_key_table();
		repeat (8) @(posedge clk_sys);
		#2;
		check_outputs('0, '0, '0); // Still in reset
		rst_n = 1'b1;
		next_cycle();
		keys_and_reset();
		joystick_paths();
		one_player_fold();
		direction_rotation();
		coin_pulses();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
